//--- rtl/mont_config.svh
// Montgomery multiplier configuration
`ifndef MONT_CONFIG_SVH
`define MONT_CONFIG_SVH

// datapath word width in bits
`define MONT_WORD_W     16
// elements in the systolic chain, one X digit each
`define MONT_NUM_PE     8
// largest operand length in words (128-bit mode)
`define MONT_MAX_WORDS  8

`endif

//--- rtl/mont_pkg.sv
// Montgomery multiplier types
`default_nettype none
`include "mont_config.svh"

package mont_pkg;

    typedef logic [`MONT_WORD_W-1:0]             word_t;
    typedef logic [`MONT_WORD_W+1:0]             carry_t;   // x*y + q*m + t + c
    typedef logic [$clog2(`MONT_MAX_WORDS):0]    count_t;

    typedef enum logic [1:0] {
        MODE_32  = 2'd0,    // 2 words
        MODE_64  = 2'd1,    // 4 words
        MODE_128 = 2'd2     // 8 words, code 3 maps here too
    } mode_e;

    typedef enum logic [1:0] {FEED_IDLE, FEED_LOAD, FEED_PAD, FEED_WAIT} feed_state_e;

    // operand length in words for a mode
    function automatic count_t words_of(mode_e mode);
        case (mode)
            MODE_32: return count_t'(2);
            MODE_64: return count_t'(4);
            default: return count_t'(8);
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rtl/word_stream_if.sv
// Word stream between chain elements
`timescale 1ns/100ps
`default_nettype none

interface word_stream_if;
    import mont_pkg::*;

    logic   valid;      // one slot per cycle
    logic   first;      // slot 0 of an operation
    logic   pad;        // trailing zero slot
    word_t  y;
    word_t  m;
    word_t  t;          // partial result word

    modport src (
        output valid, first, pad, y, m, t
    );

    modport dst (
        input  valid, first, pad, y, m, t
    );

endinterface

`default_nettype wire

//--- rtl/mont_pe.sv
// Montgomery processing element
`timescale 1ns/100ps
`default_nettype none
`include "mont_config.svh"

module mont_pe (
    input  logic            clk,
    input  logic            rstn,
    input  mont_pkg::word_t x_digit_i,
    input  mont_pkg::word_t m_prime_i,
    word_stream_if.dst      up,
    word_stream_if.src      down
);
    import mont_pkg::*;

    localparam int W     = `MONT_WORD_W;
    localparam int ACC_W = 2 * W + 2;

    logic [2*W-1:0]   xy;
    logic [2*W-1:0]   qm;
    logic [2*W-1:0]   q0_prod;
    logic [ACC_W-1:0] acc;
    word_t            q0_base;
    word_t            q_now;
    word_t            q_q;
    word_t            q_use;
    carry_t           carry_q;
    carry_t           carry_in;
    word_t            t_q;
    word_t            y_d1;
    word_t            y_d2;
    word_t            m_d1;
    word_t            m_d2;
    logic             valid_d1;
    logic             valid_d2;
    logic             first_d1;
    logic             first_d2;
    logic             pad_d1;
    logic             pad_d2;

    // ====================================================================
    // word arithmetic
    // ====================================================================
    assign xy = x_digit_i * up.y;

    // quotient digit, only meaningful on slot 0
    assign q0_base = up.t + xy[W-1:0];
    assign q0_prod = q0_base * m_prime_i;
    assign q_now   = q0_prod[W-1:0];

    assign q_use    = up.first ? q_now : q_q;
    assign carry_in = up.first ? '0 : carry_q;
    assign qm       = q_use * up.m;

    assign acc = ACC_W'(up.t) + ACC_W'(xy) + ACC_W'(qm) + ACC_W'(carry_in);

    // ====================================================================
    // pipeline registers
    // ====================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            carry_q  <= '0;
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
            first_d1 <= 1'b0;
            first_d2 <= 1'b0;
            pad_d1   <= 1'b0;
            pad_d2   <= 1'b0;
        end else begin
            carry_q  <= up.valid ? acc[ACC_W-1:W] : '0;
            valid_d1 <= up.valid;
            valid_d2 <= valid_d1;
            first_d1 <= up.first;
            first_d2 <= first_d1;
            pad_d1   <= up.pad;
            pad_d2   <= pad_d1;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.first) begin
            q_q <= q_now;   // held for the rest of the operation
        end
        // low word of slot 0 is zero by choice of q, dropped here
        t_q  <= (up.valid && !up.first) ? acc[W-1:0] : '0;
        y_d1 <= up.y;
        y_d2 <= y_d1;
        m_d1 <= up.m;
        m_d2 <= m_d1;
    end

    // t leaves one word early, which is the divide by 2^16
    assign down.valid = valid_d2;
    assign down.first = first_d2;
    assign down.pad   = pad_d2;
    assign down.y     = y_d2;
    assign down.m     = m_d2;
    assign down.t     = t_q;

endmodule

`default_nettype wire

//--- rtl/mont_pe_chain.sv
// Systolic chain of Montgomery elements
`timescale 1ns/100ps
`default_nettype none
`include "mont_config.svh"

module mont_pe_chain (
    input  logic            clk,
    input  logic            rstn,
    input  mont_pkg::mode_e mode_i,
    input  mont_pkg::word_t m_prime_i,
    input  mont_pkg::word_t x_digits_i [`MONT_NUM_PE],
    word_stream_if.dst      head,
    word_stream_if.src      tap
);
    import mont_pkg::*;

    count_t n_words;

    // link[k] feeds element k, link[k+1] is its output
    word_stream_if link [`MONT_NUM_PE+1] ();

    assign n_words = words_of(mode_i);

    assign link[0].valid = head.valid;
    assign link[0].first = head.first;
    assign link[0].pad   = head.pad;
    assign link[0].y     = head.y;
    assign link[0].m     = head.m;
    assign link[0].t     = head.t;

    for (genvar g = 0; g < `MONT_NUM_PE; g++) begin : g_pe
        word_stream_if feed ();

        // elements past the tap see no slots
        assign feed.valid = link[g].valid && (count_t'(g) < n_words);
        assign feed.first = link[g].first;
        assign feed.pad   = link[g].pad;
        assign feed.y     = link[g].y;
        assign feed.m     = link[g].m;
        assign feed.t     = link[g].t;

        mont_pe u_pe (
            .clk       (clk),
            .rstn      (rstn),
            .x_digit_i (x_digits_i[g]),
            .m_prime_i (m_prime_i),
            .up        (feed),
            .down      (link[g+1])
        );
    end

    // result leaves after element N-1
    always_comb begin
        case (mode_i)
            MODE_32: begin
                tap.valid = link[2].valid;
                tap.first = link[2].first;
                tap.pad   = link[2].pad;
                tap.y     = link[2].y;
                tap.m     = link[2].m;
                tap.t     = link[2].t;
            end
            MODE_64: begin
                tap.valid = link[4].valid;
                tap.first = link[4].first;
                tap.pad   = link[4].pad;
                tap.y     = link[4].y;
                tap.m     = link[4].m;
                tap.t     = link[4].t;
            end
            default: begin  // 128-bit, also code 3
                tap.valid = link[8].valid;
                tap.first = link[8].first;
                tap.pad   = link[8].pad;
                tap.y     = link[8].y;
                tap.m     = link[8].m;
                tap.t     = link[8].t;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mont_operand_feeder.sv
// Operand capture and stream feeder
`timescale 1ns/100ps
`default_nettype none
`include "mont_config.svh"

module mont_operand_feeder (
    input  logic            clk,
    input  logic            rstn,
    input  logic            start_i,
    input  mont_pkg::mode_e mode_i,
    input  mont_pkg::word_t m_prime_i,
    input  mont_pkg::word_t x_word_i,
    input  mont_pkg::word_t y_word_i,
    input  mont_pkg::word_t m_word_i,
    input  logic            done_i,
    output logic            busy_o,
    output mont_pkg::mode_e mode_o,
    output mont_pkg::word_t m_prime_o,
    output mont_pkg::word_t x_digits_o [`MONT_NUM_PE],
    word_stream_if.src      head
);
    import mont_pkg::*;

    feed_state_e                         state_q;
    feed_state_e                         state_d;
    logic [$clog2(`MONT_MAX_WORDS)-1:0]  cnt_q;
    count_t                              n_words;
    logic                                last_word;
    mode_e                               mode_q;
    word_t                               m_prime_q;
    word_t                               x_q [`MONT_NUM_PE];
    logic                                slot_valid_q;
    logic                                slot_first_q;
    logic                                slot_pad_q;
    word_t                               slot_y_q;
    word_t                               slot_m_q;

    assign n_words   = words_of(mode_q);
    assign last_word = (count_t'(cnt_q) == n_words - 1'b1);

    // ====================================================================
    // FSM
    // ====================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            FEED_IDLE: if (start_i)   state_d = FEED_LOAD;
            FEED_LOAD: if (last_word) state_d = FEED_PAD;
            FEED_PAD:                 state_d = FEED_WAIT;
            FEED_WAIT: if (done_i)    state_d = FEED_IDLE;
            default:                  state_d = FEED_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q      <= FEED_IDLE;
            cnt_q        <= '0;
            mode_q       <= MODE_32;
            slot_valid_q <= 1'b0;
            slot_first_q <= 1'b0;
            slot_pad_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == FEED_IDLE && start_i) begin
                mode_q <= mode_i;   // sampled in the start cycle
            end
            cnt_q        <= (state_q == FEED_LOAD) ? cnt_q + 1'b1 : '0;
            slot_valid_q <= (state_q == FEED_LOAD) || (state_q == FEED_PAD);
            slot_first_q <= (state_q == FEED_LOAD) && (cnt_q == '0);
            slot_pad_q   <= (state_q == FEED_PAD);
        end
    end

    // ====================================================================
    // operand words
    // ====================================================================
    always_ff @(posedge clk) begin
        if (state_q == FEED_IDLE && start_i) begin
            m_prime_q <= m_prime_i;
        end
        if (state_q == FEED_LOAD) begin
            x_q[cnt_q] <= x_word_i;     // digit k for element k
        end
        // zero outside the load keeps the pad slot clean
        slot_y_q <= (state_q == FEED_LOAD) ? y_word_i : '0;
        slot_m_q <= (state_q == FEED_LOAD) ? m_word_i : '0;
    end

    assign busy_o     = (state_q != FEED_IDLE);
    assign mode_o     = mode_q;
    assign m_prime_o  = m_prime_q;
    assign x_digits_o = x_q;

    assign head.valid = slot_valid_q;
    assign head.first = slot_first_q;
    assign head.pad   = slot_pad_q;
    assign head.y     = slot_y_q;
    assign head.m     = slot_m_q;
    assign head.t     = '0;     // accumulator starts at zero

endmodule

`default_nettype wire

//--- rtl/mont_result_unloader.sv
// Result word unloader
`timescale 1ns/100ps
`default_nettype none

module mont_result_unloader (
    input  logic            clk,
    input  logic            rstn,
    word_stream_if.dst      tap,
    output logic            res_valid_o,
    output mont_pkg::word_t res_word_o,
    output logic            done_o
);
    import mont_pkg::*;

    logic   word_here;
    logic   res_valid_q;
    word_t  res_word_q;

    // every valid slot but the pad carries a result word
    assign word_here = tap.valid && !tap.pad;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= word_here;
        end
    end

    always_ff @(posedge clk) begin
        if (word_here) begin
            res_word_q <= tap.t;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_word_o  = res_word_q;

    // pad sits on the tap while the last word is on the output
    assign done_o = tap.valid && tap.pad;

endmodule

`default_nettype wire

//--- rtl/mont_mul_top.sv
// Montgomery multiplier top level
`timescale 1ns/100ps
`default_nettype none
`include "mont_config.svh"

module mont_mul_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start_i,
    input  logic [1:0]              mode_i,
    input  logic [`MONT_WORD_W-1:0] m_prime_i,
    input  logic [`MONT_WORD_W-1:0] x_word_i,
    input  logic [`MONT_WORD_W-1:0] y_word_i,
    input  logic [`MONT_WORD_W-1:0] m_word_i,
    output logic                    busy_o,
    output logic                    res_valid_o,
    output logic [`MONT_WORD_W-1:0] res_word_o
);
    import mont_pkg::*;

    mode_e  op_mode;
    word_t  op_m_prime;
    word_t  x_digits [`MONT_NUM_PE];
    logic   done;

    word_stream_if head_if ();
    word_stream_if tap_if ();

    mont_operand_feeder u_feeder (
        .clk        (clk),
        .rstn       (rstn),
        .start_i    (start_i),
        .mode_i     (mode_e'(mode_i)),
        .m_prime_i  (m_prime_i),
        .x_word_i   (x_word_i),
        .y_word_i   (y_word_i),
        .m_word_i   (m_word_i),
        .done_i     (done),
        .busy_o     (busy_o),
        .mode_o     (op_mode),
        .m_prime_o  (op_m_prime),
        .x_digits_o (x_digits),
        .head       (head_if)
    );

    mont_pe_chain u_chain (
        .clk        (clk),
        .rstn       (rstn),
        .mode_i     (op_mode),
        .m_prime_i  (op_m_prime),
        .x_digits_i (x_digits),
        .head       (head_if),
        .tap        (tap_if)
    );

    mont_result_unloader u_unloader (
        .clk         (clk),
        .rstn        (rstn),
        .tap         (tap_if),
        .res_valid_o (res_valid_o),
        .res_word_o  (res_word_o),
        .done_o      (done)
    );

endmodule

`default_nettype wire

//--- verification/mont_mul_props.sv
// Montgomery multiplier timing properties
`timescale 1ns/100ps
`default_nettype none

module mont_mul_props (
    input logic clk,
    input logic rstn,
    input logic start_i,
    input logic busy_o,
    input logic res_valid_o
);

    // ====================================================================
    // busy and result timing
    // ====================================================================

    // result words only inside a busy period
    res_valid_in_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        res_valid_o |-> busy_o
    ) else $error("res_valid_o high while busy_o is low");

    busy_after_start: assert property (
        @(posedge clk) disable iff (!rstn)
        (start_i && !busy_o) |=> busy_o    // accepted start
    ) else $error("busy_o did not rise one cycle after start_i");

    // busy ends right behind the last result word
    busy_falls_after_result: assert property (
        @(posedge clk) disable iff (!rstn)
        $fell(busy_o) |-> $past(res_valid_o)
    ) else $error("busy_o fell without a result word in the cycle before");

endmodule

`default_nettype wire

//--- verification/tb_mont_mul.sv
// Montgomery multiplier testbench
`timescale 1ns/100ps
`default_nettype none
`include "mont_config.svh"

module tb_mont_mul;

    typedef logic [255:0] big_t;

    localparam int W            = `MONT_WORD_W;
    localparam int MAX_WORDS    = `MONT_MAX_WORDS;
    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 5;
    localparam int NUM_RANDOM   = 4;                    // per mode
    localparam int NUM_OPS      = 3 * NUM_RANDOM + 9 + 1 + 2;
    localparam int LIMIT_CYCLES = NUM_OPS * 64 + 200;

    logic         clk = 1'b0;
    logic         rstn;
    logic         start_i;
    logic [1:0]   mode_i;
    logic [W-1:0] m_prime_i;
    logic [W-1:0] x_word_i;
    logic [W-1:0] y_word_i;
    logic [W-1:0] m_word_i;
    logic         busy_o;
    logic         res_valid_o;
    logic [W-1:0] res_word_o;

    logic [31:0]  rng_state;
    big_t         exp_x [$];
    big_t         exp_y [$];
    big_t         exp_m [$];
    int           exp_n [$];
    int           op_count = 0;
    int           checked_count = 0;

    mont_mul_top DUT (.*);

    bind mont_mul_top mont_mul_props u_props (
        .clk         (clk),
        .rstn        (rstn),
        .start_i     (start_i),
        .busy_o      (busy_o),
        .res_valid_o (res_valid_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================================================================
    // helpers
    // ====================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [W-1:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state[W-1:0];
    endfunction

    function automatic big_t rand_operand(input int n);
        big_t v;
        v = '0;
        for (int j = 0; j < n; j++) v[W*j +: W] = rand_word();
        return v;
    endfunction

    // odd modulus, top bit of the top word clear
    function automatic big_t make_modulus(input int n);
        big_t v;
        v = rand_operand(n);
        v[0]       = 1'b1;
        v[W*n-1]   = 1'b0;
        return v;
    endfunction

    function automatic int words_for(input logic [1:0] mode);
        case (mode)
            2'd0:    return 2;
            2'd1:    return 4;
            default: return 8;  // code 3 behaves as 128-bit
        endcase
    endfunction

    // -M^-1 mod 2^16 by Newton iteration
    function automatic logic [W-1:0] m_prime_of(input logic [W-1:0] m0);
        logic [W-1:0] inv;
        inv = m0;   // already right in the low 3 bits
        for (int i = 0; i < 4; i++) inv = inv * (W'(2) - m0 * inv);
        return -inv;
    endfunction

    // expected class of T * 2^(16N) mod M
    function automatic big_t ref_residue(input big_t x, input big_t y, input big_t m);
        return (x * y) % m;
    endfunction

    task automatic check_value(input string name, input big_t actual, input big_t expected);
        if (actual !== expected) begin
            $display("** Error: %s got %0h, expected %0h", name, actual, expected);
            $display("test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic collect_result(output big_t t_val, output int n_got);
        t_val = '0;
        n_got = 0;
        while (res_valid_o !== 1'b1) @(negedge clk);
        while (res_valid_o === 1'b1) begin
            if (n_got < MAX_WORDS) t_val[W*n_got +: W] = res_word_o;
            n_got++;
            @(negedge clk);
        end
    endtask

    // start one operation, optionally with start pulses that must be ignored
    task automatic run_op(input logic [1:0] mode, input big_t x, input big_t y,
                          input big_t m, input bit pulse_ignored);
        int           n;
        logic [W-1:0] mp;
        n  = words_for(mode);
        mp = m_prime_of(m[W-1:0]);
        next_drive_slot();
        while (busy_o !== 1'b0) next_drive_slot();
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_m.push_back(m);
        exp_n.push_back(n);
        op_count++;
        start_i   = 1'b1;
        mode_i    = mode;
        m_prime_i = mp;
        next_drive_slot();
        start_i   = 1'b0;
        mode_i    = ~mode;  // only the start cycle counts
        m_prime_i = ~mp;
        for (int j = 0; j < n; j++) begin
            x_word_i = x[W*j +: W];
            y_word_i = y[W*j +: W];
            m_word_i = m[W*j +: W];
            start_i  = pulse_ignored && (j > 0);
            next_drive_slot();
        end
        if (pulse_ignored) begin
            start_i  = 1'b1;
            x_word_i = rand_word();
            y_word_i = rand_word();
            m_word_i = rand_word();
            next_drive_slot();
        end
        start_i  = 1'b0;
        x_word_i = '0;
        y_word_i = '0;
        m_word_i = '0;
    endtask

    // ====================================================================
    // stimulus
    // ====================================================================
    initial begin : stimulus
        big_t       x;
        big_t       y;
        big_t       m;
        logic [1:0] md;
        rng_state = 32'hae1d;
        rstn      = 1'b0;
        start_i   = 1'b0;
        mode_i    = 2'd0;
        m_prime_i = '0;
        x_word_i  = '0;
        y_word_i  = '0;
        m_word_i  = '0;
        repeat (4) @(posedge clk);
        #(DRIVE_DLY);
        rstn = 1'b1;

        repeat (6) begin    // idle after reset
            @(negedge clk);
            check_value("busy_o", big_t'(busy_o), '0);
            check_value("res_valid_o", big_t'(res_valid_o), '0);
        end

        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < NUM_RANDOM; i++) begin
                md = 2'(k);
                m  = make_modulus(words_for(md));
                x  = rand_operand(words_for(md)) % m;
                y  = rand_operand(words_for(md)) % m;
                run_op(md, x, y, m, 1'b0);
            end
        end

        for (int k = 0; k < 3; k++) begin   // edge operands
            md = 2'(k);
            m  = make_modulus(words_for(md));
            y  = rand_operand(words_for(md)) % m;
            run_op(md, '0, y, m, 1'b0);
            run_op(md, big_t'(1), big_t'(1), m, 1'b0);
            run_op(md, m - 1, m - 1, m, 1'b0);
        end

        m = make_modulus(4);
        run_op(2'd1, rand_operand(4) % m, rand_operand(4) % m, m, 1'b1);

        // back to back, mode changes between them
        m = make_modulus(8);
        run_op(2'd2, rand_operand(8) % m, rand_operand(8) % m, m, 1'b0);
        m = make_modulus(2);
        run_op(2'd0, rand_operand(2) % m, rand_operand(2) % m, m, 1'b0);

        while (checked_count < op_count) @(posedge clk);
        repeat (40) @(posedge clk);
        check_value("busy_o", big_t'(busy_o), '0);
        $display("test passed");
        $finish;
    end

    // ====================================================================
    // result comparison
    // ====================================================================
    initial begin : result_monitor
        big_t t_val;
        big_t x;
        big_t y;
        big_t m;
        int   n_exp;
        int   n_got;
        forever begin
            collect_result(t_val, n_got);
            if (exp_n.size() == 0) begin
                $display("Error: a result burst arrived with no operation pending");
                $display("test failed");
                $fatal(1, "unexpected result burst");
            end else begin
                x     = exp_x.pop_front();
                y     = exp_y.pop_front();
                m     = exp_m.pop_front();
                n_exp = exp_n.pop_front();
                check_value("res_valid_o word count", big_t'(n_got), big_t'(n_exp));
                check_value("res_word_o T*R mod M", (t_val << (W * n_exp)) % m,
                            ref_residue(x, y, m));
                check_value("res_word_o T < 2M", big_t'(t_val < (m << 1)), big_t'(1));
                if (x == '0) check_value("res_word_o for X = 0", t_val, '0);
                checked_count++;
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * LIMIT_CYCLES);
        $display("Error: no progress within %0d cycles, a result never arrived", LIMIT_CYCLES);
        $display("test failed");
        $fatal(1, "simulation timed out");
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/mont_pkg.sv
rtl/word_stream_if.sv
rtl/mont_pe.sv
rtl/mont_pe_chain.sv
rtl/mont_operand_feeder.sv
rtl/mont_result_unloader.sv
rtl/mont_mul_top.sv
verification/mont_mul_props.sv
verification/tb_mont_mul.sv

//--- run.sh
#!/bin/sh
# compile and run the Montgomery multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mont_mul -f project.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_mont_mul
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

echo "simulation ended with status 0"
exit 0
